// File: vlog.f
common/eeprom_pkg.sv
i2c_master/scl_gen.sv
i2c_master/bit_engine.sv
design/eeprom_regs.sv
design/eeprom_seq.sv
design/eeprom_wr.sv
bench/eeprom_model.sv
bench/tb_eeprom_wr.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then scan the log for the fail line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_eeprom_wr -f vlog.f \
  > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vtb_eeprom_wr > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: bench/tb_eeprom_wr.sv
`timescale 1ns/1ps
module tb_eeprom_wr;
  import eeprom_pkg::*;

  localparam int n_xfers  = 40;  // transfers over all tests
  localparam int bits_max = 60;  // scl bits allowed per transfer
  localparam int clk_per  = 8;

  logic              clk;
  logic              rst_n;
  logic              wr, rd;
  logic [addr_w-1:0] addr;
  logic [7:0]        wdata;
  logic [7:0]        rdata;
  logic              ack, busy, nack_err, scl, sda_drive_low;
  logic              model_low, respond;
  wire               sda;
  logic [7:0]        mirror [0:(1 << addr_w) - 1];
  logic [7:0]        last_read;  // byte the last good read should have returned
  integer            seed;
  int                errors, test_fails, tests_run;

  assign sda = !(sda_drive_low || model_low);  // open drain, pulled up

  eeprom_wr UUT (
    .clk, .rst_n, .wr, .rd, .addr, .wdata, .rdata, .ack, .busy, .nack_err,
    .scl, .sda_drive_low, .sda_in(sda)
  );

  eeprom_model u_model (.clk, .rst_n, .respond, .scl, .sda, .sda_low(model_low));

  always #4 clk = !clk;

  initial begin
    #(n_xfers * bits_max * 4 * scl_quarter * clk_per);
    $display("timeout: the DUT did not finish its transfers in time");
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [7:0] exp, input logic [7:0] act);
    $display("ERROR %s: %s expected %0h actual %0h", test, what, exp, act);
    errors++;
  endtask

  task automatic strobe(input logic w, input logic r, input logic [addr_w-1:0] a,
                        input logic [7:0] d);
    @(posedge clk);
    #1;
    wr    = w;
    rd    = r;
    addr  = a;
    wdata = d;
    @(posedge clk);
    #1;
    wr = 1'b0;
    rd = 1'b0;
  endtask

  task automatic wait_ack;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
  endtask

  task automatic write_byte(input logic [addr_w-1:0] a, input logic [7:0] d);
    strobe(1'b1, 1'b0, a, d);
    wait_ack();
    if (respond)
      mirror[a] = d;
  endtask

  task automatic read_byte(input logic [addr_w-1:0] a);
    strobe(1'b0, 1'b1, a, 8'h00);
    wait_ack();
    if (respond)
      last_read = mirror[a];
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fails++;
      $display("test %s: %0d error(s)", name, errors - err_start);
    end
  endtask

  task automatic test_reset;
    int e0;
    e0 = errors;
    if (scl !== 1'b1) report_mismatch("reset", "scl", 8'h01, 8'(scl));
    if (sda_drive_low !== 1'b0) report_mismatch("reset", "sda_drive_low", 8'h00,
                                                8'(sda_drive_low));
    if (busy !== 1'b0) report_mismatch("reset", "busy", 8'h00, 8'(busy));
    if (ack !== 1'b0) report_mismatch("reset", "ack", 8'h00, 8'(ack));
    if (nack_err !== 1'b0) report_mismatch("reset", "nack_err", 8'h00, 8'(nack_err));
    if (rdata !== 8'h00) report_mismatch("reset", "rdata", 8'h00, rdata);
    finish_test("reset", e0);
  endtask

  task automatic test_write_read;
    logic [addr_w-1:0] a [8];
    int e0;
    e0 = errors;
    for (int p = 0; p < 8; p++) begin
      a[p] = {p[page_w-1:0], 8'($random(seed))};  // one address per page
      write_byte(a[p], 8'($random(seed)));
      if (nack_err !== 1'b0) report_mismatch("write_read", "write nack_err", 8'h00,
                                             8'(nack_err));
    end
    for (int p = 0; p < 8; p++) begin
      read_byte(a[p]);
      if (rdata !== mirror[a[p]]) report_mismatch("write_read", "rdata", mirror[a[p]], rdata);
      if (nack_err !== 1'b0) report_mismatch("write_read", "read nack_err", 8'h00,
                                             8'(nack_err));
    end
    finish_test("write_read", e0);
  endtask

  task automatic test_pages;
    logic [7:0] low;
    int e0;
    e0 = errors;
    low = 8'($random(seed));
    for (int p = 0; p < 8; p++)
      write_byte({p[page_w-1:0], low}, 8'(8'h3c ^ (p * 8'h25)));
    for (int p = 0; p < 8; p++) begin
      read_byte({p[page_w-1:0], low});
      if (rdata !== 8'(8'h3c ^ (p * 8'h25)))
        report_mismatch("pages", "rdata", 8'(8'h3c ^ (p * 8'h25)), rdata);
    end
    finish_test("pages", e0);
  endtask

  task automatic test_busy;
    logic [addr_w-1:0] a, b;
    logic [7:0] old_b;
    int e0;
    e0 = errors;
    a     = 11'h123;
    b     = 11'h3c7;
    old_b = mirror[b];
    strobe(1'b1, 1'b0, a, 8'h5e);
    repeat (10) @(posedge clk);
    #1;
    if (busy !== 1'b1) report_mismatch("busy", "busy during write", 8'h01, 8'(busy));
    strobe(1'b1, 1'b0, b, ~old_b);  // must be dropped
    wait_ack();
    mirror[a] = 8'h5e;
    if (u_model.mem[b] !== old_b) report_mismatch("busy", "model byte", old_b, u_model.mem[b]);
    read_byte(b);
    if (rdata !== old_b) report_mismatch("busy", "rdata of dropped write", old_b, rdata);
    read_byte(a);
    if (rdata !== mirror[a]) report_mismatch("busy", "rdata of first write", mirror[a], rdata);
    finish_test("busy", e0);
  endtask

  task automatic test_priority;
    logic [addr_w-1:0] c;
    logic [7:0] prev;
    int e0;
    e0 = errors;
    c    = 11'h6e1;
    prev = last_read;
    strobe(1'b1, 1'b1, c, ~prev);
    wait_ack();
    mirror[c] = ~prev;
    if (rdata !== prev) report_mismatch("priority", "rdata kept", prev, rdata);
    if (nack_err !== 1'b0) report_mismatch("priority", "nack_err", 8'h00, 8'(nack_err));
    if (u_model.mem[c] !== mirror[c])
      report_mismatch("priority", "model byte", mirror[c], u_model.mem[c]);
    read_byte(c);
    if (rdata !== mirror[c]) report_mismatch("priority", "rdata", mirror[c], rdata);
    finish_test("priority", e0);
  endtask

  task automatic test_nack;
    logic [addr_w-1:0] a;
    logic [7:0] prev, old;
    int e0;
    e0 = errors;
    a       = 11'h2f0;
    old     = mirror[a];
    prev    = last_read;
    respond = 1'b0;
    write_byte(a, ~old);
    if (nack_err !== 1'b1) report_mismatch("nack", "write nack_err", 8'h01, 8'(nack_err));
    if (rdata !== prev) report_mismatch("nack", "rdata after write", prev, rdata);
    read_byte(a);
    if (nack_err !== 1'b1) report_mismatch("nack", "read nack_err", 8'h01, 8'(nack_err));
    if (rdata !== prev) report_mismatch("nack", "rdata after read", prev, rdata);
    respond = 1'b1;
    read_byte(a);
    if (nack_err !== 1'b0) report_mismatch("nack", "nack_err cleared", 8'h00, 8'(nack_err));
    if (rdata !== old) report_mismatch("nack", "rdata after recovery", old, rdata);
    finish_test("nack", e0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wr         = 1'b0;
    rd         = 1'b0;
    addr       = '0;
    wdata      = '0;
    respond    = 1'b1;
    last_read  = 8'h00;
    seed       = 32'h359c03db;
    errors     = 0;
    test_fails = 0;
    tests_run  = 0;
    for (int i = 0; i < (1 << addr_w); i++)
      mirror[i] = 8'hff;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_write_read();
    test_pages();
    test_busy();
    test_priority();
    test_nack();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, test_fails, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: bench/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
  input  logic clk,
  input  logic rst_n,
  input  logic respond,   // low makes the slave ignore its address
  input  logic scl,
  input  logic sda,
  output logic sda_low
);
  import eeprom_pkg::*;

  typedef enum logic [2:0] {m_idle, m_ctrl, m_addr, m_data, m_send} model_phase_t;

  logic [7:0]        mem [0:(1 << addr_w) - 1];
  model_phase_t      phase, next_phase;
  logic [3:0]        bit_cnt;   // 8 data bits, then the ack slot
  logic [7:0]        shreg;
  logic [7:0]        txreg;
  logic [page_w-1:0] page;
  logic [addr_w-1:0] ptr;
  logic              scl_q, sda_q;
  ctrl_byte_t        ctrl;

  always_comb ctrl.raw = shreg;

  always @(posedge clk) begin
    scl_q <= scl;
    sda_q <= sda;
    if (!rst_n) begin
      for (int i = 0; i < (1 << addr_w); i++)
        mem[i] <= 8'hff;
      phase      <= m_idle;
      next_phase <= m_idle;
      bit_cnt    <= '0;
      sda_low    <= 1'b0;
    end else if (scl && scl_q && sda_q && !sda) begin
      phase   <= m_ctrl;  // start or repeated start
      bit_cnt <= '0;
    end else if (scl && scl_q && !sda_q && sda) begin
      phase   <= m_idle;  // stop
      sda_low <= 1'b0;
    end else if (scl && !scl_q) begin
      if (bit_cnt < 4'd8)
        shreg <= {shreg[6:0], sda};
      bit_cnt <= bit_cnt + 4'd1;
    end else if (!scl && scl_q && phase != m_idle) begin
      if (bit_cnt == 4'd8) begin
        sda_low <= 1'b0;
        if (!respond && phase != m_send) begin
          phase <= m_idle;
        end else begin
          case (phase)
            m_ctrl: begin
              if (ctrl.fields.dev == dev_type) begin
                sda_low    <= 1'b1;
                page       <= ctrl.fields.page;
                next_phase <= ctrl.fields.rw ? m_send : m_addr;
              end else begin
                phase <= m_idle;
              end
            end
            m_addr: begin
              sda_low    <= 1'b1;
              ptr        <= {page, shreg};
              next_phase <= m_data;
            end
            m_data: begin
              sda_low    <= 1'b1;
              mem[ptr]   <= shreg;
              next_phase <= m_idle;
            end
            default: next_phase <= m_idle;  // released for the master nack
          endcase
        end
      end else if (bit_cnt == 4'd9) begin
        bit_cnt <= '0;
        phase   <= next_phase;
        sda_low <= 1'b0;
        if (next_phase == m_send) begin
          txreg   <= mem[ptr];
          sda_low <= !mem[ptr][7];
        end
      end else if (phase == m_send) begin
        sda_low <= !txreg[6];  // msb first
        txreg   <= {txreg[6:0], 1'b0};
      end
    end
  end

endmodule

// File: design/eeprom_wr.sv
`timescale 1ns/1ps
module eeprom_wr (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::addr_w-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic [7:0]                    rdata,
  output logic                          ack,
  output logic                          busy,
  output logic                          nack_err,
  output logic                          scl,
  output logic                          sda_drive_low,
  input  logic                          sda_in
);
  import eeprom_pkg::*;

  logic              req_valid, req_read;
  logic [addr_w-1:0] req_addr;
  logic [7:0]        req_wdata;
  logic              xfer_done, xfer_nack;
  logic [7:0]        xfer_rdata;
  bit_cmd_t          cmd;
  logic [7:0]        tx_data, rx_data;
  logic              cmd_done, rx_ack, run;
  logic              q_low_mid, q_rise, q_high_mid, q_fall;

  eeprom_regs u_regs (
    .clk, .rst_n, .wr, .rd, .addr, .wdata,
    .xfer_done, .xfer_nack, .xfer_rdata,
    .req_valid, .req_read, .req_addr, .req_wdata,
    .busy, .ack, .rdata, .nack_err
  );

  eeprom_seq u_seq (
    .clk, .rst_n, .req_valid, .req_read, .req_addr, .req_wdata,
    .cmd_done, .rx_ack, .rx_data,
    .cmd, .tx_data, .xfer_done, .xfer_nack, .xfer_rdata
  );

  bit_engine u_bit (
    .clk, .rst_n, .cmd, .tx_data, .sda_in,
    .q_low_mid, .q_rise, .q_high_mid, .q_fall,
    .run, .sda_drive_low, .cmd_done, .rx_data, .rx_ack
  );

  scl_gen u_scl (
    .clk, .rst_n, .run, .scl,
    .q_low_mid, .q_rise, .q_high_mid, .q_fall
  );

endmodule

// File: design/eeprom_seq.sv
`timescale 1ns/1ps
module eeprom_seq (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_valid,
  input  logic                          req_read,
  input  logic [eeprom_pkg::addr_w-1:0] req_addr,
  input  logic [7:0]                    req_wdata,
  input  logic                          cmd_done,
  input  logic                          rx_ack,
  input  logic [7:0]                    rx_data,
  output eeprom_pkg::bit_cmd_t          cmd,
  output logic [7:0]                    tx_data,
  output logic                          xfer_done,
  output logic                          xfer_nack,
  output logic [7:0]                    xfer_rdata
);
  import eeprom_pkg::*;

  seq_state_t state;
  ctrl_byte_t ctrl;

  // page bits ride in the control byte
  always_comb begin
    ctrl.fields.dev  = dev_type;
    ctrl.fields.page = req_addr[addr_w-1 -: page_w];
    ctrl.fields.rw   = (state == st_ctrl_rd);
  end

  always_comb begin
    cmd     = cmd_none;
    tx_data = 8'h00;
    case (state)
      st_wr_start, st_rd_start: cmd = cmd_start;
      st_ctrl_wr, st_ctrl_rd: begin
        cmd     = cmd_tx_byte;
        tx_data = ctrl.raw;
      end
      st_addr_wr: begin
        cmd     = cmd_tx_byte;
        tx_data = req_addr[7:0];  // word address
      end
      st_data_wr: begin
        cmd     = cmd_tx_byte;
        tx_data = req_wdata;
      end
      st_data_rd: cmd = cmd_rx_byte;
      st_stop:    cmd = cmd_stop;
      default:    cmd = cmd_none;
    endcase
  end

  assign xfer_done = (state == st_finish);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      xfer_nack <= 1'b0;
    end else begin
      case (state)
        st_idle:
          if (req_valid) begin
            xfer_nack <= 1'b0;
            state     <= st_wr_start;
          end
        st_wr_start:
          if (cmd_done) state <= st_ctrl_wr;
        st_ctrl_wr:
          if (cmd_done) begin
            if (!rx_ack) begin
              xfer_nack <= 1'b1;
              state     <= st_stop;
            end else begin
              state <= st_addr_wr;
            end
          end
        st_addr_wr:
          if (cmd_done) begin
            if (!rx_ack) begin
              xfer_nack <= 1'b1;
              state     <= st_stop;
            end else begin
              state <= req_read ? st_rd_start : st_data_wr;
            end
          end
        st_data_wr:
          if (cmd_done) begin
            xfer_nack <= !rx_ack;
            state     <= st_stop;
          end
        st_rd_start:
          if (cmd_done) state <= st_ctrl_rd;
        st_ctrl_rd:
          if (cmd_done) begin
            if (!rx_ack) begin
              xfer_nack <= 1'b1;
              state     <= st_stop;
            end else begin
              state <= st_data_rd;
            end
          end
        st_data_rd:
          if (cmd_done) state <= st_stop;
        st_stop:
          if (cmd_done) state <= st_finish;
        default: state <= st_idle;  // finish lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_data_rd && cmd_done)
      xfer_rdata <= rx_data;
  end

endmodule

// File: design/eeprom_regs.sv
`timescale 1ns/1ps
module eeprom_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::addr_w-1:0] addr,
  input  logic [7:0]                    wdata,
  input  logic                          xfer_done,
  input  logic                          xfer_nack,
  input  logic [7:0]                    xfer_rdata,
  output logic                          req_valid,
  output logic                          req_read,
  output logic [eeprom_pkg::addr_w-1:0] req_addr,
  output logic [7:0]                    req_wdata,
  output logic                          busy,
  output logic                          ack,
  output logic [7:0]                    rdata,
  output logic                          nack_err
);

  logic accept;

  assign accept = !busy && (wr || rd);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      req_read  <= 1'b0;
      busy      <= 1'b0;
      ack       <= 1'b0;
      rdata     <= 8'h00;
      nack_err  <= 1'b0;
    end else begin
      ack <= 1'b0;
      if (accept) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
        req_read  <= !wr;  // wr wins over rd
      end
      if (xfer_done) begin
        req_valid <= 1'b0;
        busy      <= 1'b0;
        ack       <= 1'b1;
        nack_err  <= xfer_nack;
        if (req_read && !xfer_nack)
          rdata <= xfer_rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= addr;
      req_wdata <= wdata;
    end
  end

endmodule

// File: i2c_master/bit_engine.sv
`timescale 1ns/1ps
module bit_engine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  eeprom_pkg::bit_cmd_t cmd,
  input  logic [7:0]           tx_data,
  input  logic                 sda_in,
  input  logic                 q_low_mid,
  input  logic                 q_rise,
  input  logic                 q_high_mid,
  input  logic                 q_fall,
  output logic                 run,
  output logic                 sda_drive_low,
  output logic                 cmd_done,
  output logic [7:0]           rx_data,
  output logic                 rx_ack
);
  import eeprom_pkg::*;

  bit_state_t state;
  logic [7:0] tx_shift;
  logic [3:0] bit_cnt;     // 0..7 data bits, 8 = ack slot
  logic       scl_high;    // tracks the scl level from the strobes

  always_ff @(posedge clk) begin
    if (!rst_n || !run)
      scl_high <= 1'b1;
    else if (q_rise)
      scl_high <= 1'b1;
    else if (q_fall)
      scl_high <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= b_idle;
      run           <= 1'b0;
      sda_drive_low <= 1'b0;
      cmd_done      <= 1'b0;
      rx_ack        <= 1'b0;
      bit_cnt       <= '0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        b_idle: begin
          bit_cnt <= '0;
          // cmd is still the old one while cmd_done is high
          if (!cmd_done) begin
            case (cmd)
              cmd_start: begin
                state <= b_start;
                run   <= 1'b1;
              end
              cmd_stop:    state <= b_stop;
              cmd_tx_byte: state <= b_tx;
              cmd_rx_byte: state <= b_rx;
              default:     state <= b_idle;
            endcase
          end
        end
        b_start: begin
          if (q_low_mid) begin
            sda_drive_low <= 1'b0;  // release before the high phase
            bit_cnt       <= 4'd1;
          end
          if (q_high_mid && bit_cnt != 4'd0 && scl_high) begin
            sda_drive_low <= 1'b1;  // sda falls with scl high
            cmd_done      <= 1'b1;
            state         <= b_idle;
          end
        end
        b_stop: begin
          if (q_low_mid) begin
            sda_drive_low <= 1'b1;
            bit_cnt       <= 4'd1;
          end
          if (q_high_mid && bit_cnt != 4'd0 && scl_high) begin
            sda_drive_low <= 1'b0;  // sda rises with scl high
            run           <= 1'b0;
            cmd_done      <= 1'b1;
            state         <= b_idle;
          end
        end
        b_tx: begin
          if (q_low_mid)
            sda_drive_low <= (bit_cnt == 4'd8) ? 1'b0 : !tx_shift[7];
          if (q_high_mid) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8) begin
              rx_ack   <= !sda_in;  // slave pulls low to ack
              cmd_done <= 1'b1;
              state    <= b_idle;
            end
          end
        end
        default: begin
          // rx: sda stays released, ninth bit is the master nack
          if (q_low_mid)
            sda_drive_low <= 1'b0;
          if (q_high_mid) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8) begin
              cmd_done <= 1'b1;
              state    <= b_idle;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == b_idle)
      tx_shift <= tx_data;
    else if (state == b_tx && q_low_mid && bit_cnt != 4'd8)
      tx_shift <= {tx_shift[6:0], 1'b0};
    if (state == b_rx && q_high_mid && bit_cnt != 4'd8)
      rx_data <= {rx_data[6:0], sda_in};  // msb first
  end

endmodule

// File: i2c_master/scl_gen.sv
`timescale 1ns/1ps
module scl_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic scl,
  output logic q_low_mid,
  output logic q_rise,
  output logic q_high_mid,
  output logic q_fall
);
  import eeprom_pkg::*;

  logic [q_cnt_w-1:0] sub_cnt;
  logic [1:0]         quarter;   // 0,1 low half; 2,3 high half
  logic               quarter_end;

  assign quarter_end = (sub_cnt == q_cnt_w'(scl_quarter - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      sub_cnt    <= '0;
      quarter    <= '0;
      scl        <= 1'b1;  // bus idles high
      q_low_mid  <= 1'b0;
      q_rise     <= 1'b0;
      q_high_mid <= 1'b0;
      q_fall     <= 1'b0;
    end else begin
      q_low_mid  <= 1'b0;
      q_rise     <= 1'b0;
      q_high_mid <= 1'b0;
      q_fall     <= 1'b0;
      if (quarter_end) begin
        sub_cnt <= '0;
        quarter <= quarter + 2'd1;
        case (quarter)
          2'd0: q_low_mid <= 1'b1;
          2'd1: begin
            q_rise <= 1'b1;
            scl    <= 1'b1;
          end
          2'd2: q_high_mid <= 1'b1;
          default: begin
            q_fall <= 1'b1;
            scl    <= 1'b0;
          end
        endcase
      end else begin
        sub_cnt <= sub_cnt + 1'b1;
      end
    end
  end

endmodule

// File: common/eeprom_pkg.sv
package eeprom_pkg;

  localparam int addr_w      = 11;
  localparam int page_w      = 3;
  localparam logic [3:0] dev_type = 4'b1010;  // 24cxx device type
  localparam int scl_quarter = 4;              // clk cycles per quarter of scl
  localparam int q_cnt_w     = $clog2(scl_quarter);

  // control byte, built field by field and shifted out as a whole
  typedef struct packed {
    logic [3:0]        dev;
    logic [page_w-1:0] page;
    logic              rw;   // 1 = read
  } ctrl_fields_t;

  typedef union packed {
    ctrl_fields_t fields;
    logic [7:0]   raw;
  } ctrl_byte_t;

  typedef enum logic [9:0] {
    st_idle     = 10'b00_0000_0001,
    st_wr_start = 10'b00_0000_0010,
    st_ctrl_wr  = 10'b00_0000_0100,
    st_addr_wr  = 10'b00_0000_1000,
    st_data_wr  = 10'b00_0001_0000,
    st_rd_start = 10'b00_0010_0000,
    st_ctrl_rd  = 10'b00_0100_0000,
    st_data_rd  = 10'b00_1000_0000,
    st_stop     = 10'b01_0000_0000,
    st_finish   = 10'b10_0000_0000
  } seq_state_t;

  typedef enum logic [2:0] {b_idle, b_start, b_stop, b_tx, b_rx} bit_state_t;

  typedef enum logic [2:0] {cmd_none, cmd_start, cmd_stop, cmd_tx_byte, cmd_rx_byte} bit_cmd_t;

endpackage
